// ==== serv_pkg.sv ====
`default_nettype none

package serv_pkg;

   localparam int XLEN       = 32;
   localparam int CNT_W      = 5;
   localparam int REG_ADDR_W = 5;
   localparam int INSTR_W    = 32;

   localparam logic [XLEN-1:0] DEFAULT_RESET_PC = 32'h0000_0000;

   // Major opcodes, instruction bits 6:0
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   typedef enum logic [1:0] {
      ALU_ADD,
      ALU_XOR,
      ALU_OR,
      ALU_AND
   } alu_op_t;

   // Where the rd bit comes from
   typedef enum logic [1:0] {
      RD_ALU,
      RD_CTRL,
      RD_IMM,
      RD_NONE
   } rd_src_t;

   typedef enum logic [1:0] {
      IMM_I,
      IMM_U,
      IMM_J
   } imm_fmt_t;

endpackage

`default_nettype wire

// ==== serv_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_state (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_done
);

   typedef enum logic [1:0] {
      ST_UPDATE,
      ST_FETCH,
      ST_REQ,
      ST_EXEC
   } state_t;

   state_t                     state;
   state_t                     state_nxt;
   logic [serv_pkg::CNT_W-1:0] cnt;

   always_comb begin
      state_nxt = state;
      case (state)
         // PC holds the next fetch address
         ST_UPDATE: begin
            state_nxt = ST_FETCH;
         end
         ST_FETCH: begin
            if (i_ibus_ack) begin
               state_nxt = ST_REQ;
            end
         end
         // One-cycle read request to the register file
         ST_REQ: begin
            state_nxt = ST_EXEC;
         end
         default: begin
            if (o_cnt_done) begin
               state_nxt = ST_FETCH;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state <= ST_UPDATE;
         cnt   <= '0;
      end else begin
         state <= state_nxt;
         // Wraps back to zero after the last bit
         if (o_cnt_en) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_rf_rreq  = (state == ST_REQ);
   assign o_cnt_en   = (state == ST_EXEC);
   assign o_cnt0     = o_cnt_en & (cnt == '0);
   assign o_cnt_done = o_cnt_en & (&cnt);

endmodule

`default_nettype wire

// ==== serv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_decode (
   input  logic                         clk,
   input  logic                         i_rst_n,
   input  logic                         i_ibus_ack,
   input  logic [serv_pkg::INSTR_W-1:0] i_ibus_rdt,
   output serv_pkg::alu_op_t            o_alu_op,
   output logic                         o_sub,
   output logic                         o_op_b_imm,
   output serv_pkg::rd_src_t            o_rd_src,
   output serv_pkg::imm_fmt_t           o_imm_fmt,
   output logic                         o_pc_jump,
   output logic                         o_pc_rel
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       funct7_5;
   logic       is_op;
   logic       is_op_imm;
   logic       f3_ok;
   logic       alu_ok;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         opcode   <= '0;
         funct3   <= '0;
         funct7_5 <= 1'b0;
      end else if (i_ibus_ack) begin
         opcode   <= i_ibus_rdt[6:0];
         funct3   <= i_ibus_rdt[14:12];
         funct7_5 <= i_ibus_rdt[30];
      end
   end

   assign is_op     = (opcode == serv_pkg::OPC_OP);
   assign is_op_imm = (opcode == serv_pkg::OPC_OP_IMM);
   assign f3_ok     = funct3 inside {serv_pkg::F3_ADD, serv_pkg::F3_XOR,
                                     serv_pkg::F3_OR, serv_pkg::F3_AND};

   // funct7 bit 5 on an OP is only legal for SUB
   assign alu_ok = f3_ok & (is_op_imm | (is_op & (~funct7_5 | (funct3 == serv_pkg::F3_ADD))));

   assign o_sub      = is_op & funct7_5 & (funct3 == serv_pkg::F3_ADD);
   assign o_op_b_imm = is_op_imm;
   assign o_pc_jump  = (opcode == serv_pkg::OPC_JAL);
   assign o_pc_rel   = (opcode == serv_pkg::OPC_AUIPC);

   always_comb begin
      case (funct3)
         serv_pkg::F3_XOR: o_alu_op = serv_pkg::ALU_XOR;
         serv_pkg::F3_OR:  o_alu_op = serv_pkg::ALU_OR;
         serv_pkg::F3_AND: o_alu_op = serv_pkg::ALU_AND;
         default:          o_alu_op = serv_pkg::ALU_ADD;
      endcase
   end

   always_comb begin
      if (alu_ok) begin
         o_rd_src = serv_pkg::RD_ALU;
      end else if (opcode == serv_pkg::OPC_LUI) begin
         o_rd_src = serv_pkg::RD_IMM;
      end else if (o_pc_jump | o_pc_rel) begin
         o_rd_src = serv_pkg::RD_CTRL;
      end else begin
         o_rd_src = serv_pkg::RD_NONE;
      end
   end

   // Taken from the bus word so the immediate can be built in the ack cycle
   always_comb begin
      case (i_ibus_rdt[6:0])
         serv_pkg::OPC_LUI,
         serv_pkg::OPC_AUIPC: o_imm_fmt = serv_pkg::IMM_U;
         serv_pkg::OPC_JAL:   o_imm_fmt = serv_pkg::IMM_J;
         default:             o_imm_fmt = serv_pkg::IMM_I;
      endcase
   end

endmodule

`default_nettype wire

// ==== serv_immdec.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_immdec (
   input  logic                            clk,
   input  logic                            i_ibus_ack,
   input  logic [serv_pkg::INSTR_W-1:0]    i_ibus_rdt,
   input  serv_pkg::imm_fmt_t              i_imm_fmt,
   input  logic                            i_cnt_en,
   output logic                            o_imm,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rd_addr,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rs1_addr,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rs2_addr
);

   logic [serv_pkg::XLEN-1:0] imm;
   logic [serv_pkg::XLEN-1:0] imm_new;

   always_comb begin
      case (i_imm_fmt)
         serv_pkg::IMM_U: begin
            imm_new = {i_ibus_rdt[31:12], 12'b0};
         end
         serv_pkg::IMM_J: begin
            imm_new = {{12{i_ibus_rdt[31]}}, i_ibus_rdt[19:12], i_ibus_rdt[20],
                       i_ibus_rdt[30:21], 1'b0};
         end
         default: begin
            imm_new = {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_rd_addr  <= i_ibus_rdt[11:7];
         o_rs1_addr <= i_ibus_rdt[19:15];
         o_rs2_addr <= i_ibus_rdt[24:20];
         imm        <= imm_new;
      end else if (i_cnt_en) begin
         // LSB first, sign bit stays in place
         imm <= {imm[serv_pkg::XLEN-1], imm[serv_pkg::XLEN-1:1]};
      end
   end

   assign o_imm = imm[0];

endmodule

`default_nettype wire

// ==== serv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_alu (
   input  logic              clk,
   input  logic              i_rst_n,
   input  logic              i_cnt_en,
   input  logic              i_cnt0,
   input  serv_pkg::alu_op_t i_alu_op,
   input  logic              i_sub,
   input  logic              i_op_b_imm,
   input  logic              i_rs1,
   input  logic              i_rs2,
   input  logic              i_imm,
   output logic              o_rd
);

   logic op_b;
   logic add_b;
   logic carry_q;
   logic carry_in;
   logic sum;
   logic carry_out;

   assign op_b  = i_op_b_imm ? i_imm : i_rs2;
   // Two's complement subtract, the +1 comes in through the carry
   assign add_b = op_b ^ i_sub;

   assign carry_in  = i_cnt0 ? i_sub : carry_q;
   assign sum       = i_rs1 ^ add_b ^ carry_in;
   assign carry_out = (i_rs1 & add_b) | (carry_in & (i_rs1 ^ add_b));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_q <= 1'b0;
      end else if (i_cnt_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_alu_op)
         serv_pkg::ALU_XOR: o_rd = i_rs1 ^ op_b;
         serv_pkg::ALU_OR:  o_rd = i_rs1 | op_b;
         serv_pkg::ALU_AND: o_rd = i_rs1 & op_b;
         default:           o_rd = sum;
      endcase
   end

endmodule

`default_nettype wire

// ==== serv_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_ctrl #(
   parameter logic [serv_pkg::XLEN-1:0] RESET_PC = serv_pkg::DEFAULT_RESET_PC
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  logic                      i_cnt_en,
   input  logic                      i_cnt0,
   input  logic                      i_pc_jump,
   input  logic                      i_pc_rel,
   input  logic                      i_imm,
   output logic [serv_pkg::XLEN-1:0] o_ibus_adr,
   output logic                      o_rd
);

   logic [serv_pkg::XLEN-1:0] pc;
   logic                      cnt1_q;
   logic                      cnt2_q;
   logic                      c4_q;
   logic                      ci_q;
   logic                      c4_in;
   logic                      ci_in;
   logic                      pc4_bit;
   logic                      pcimm_bit;
   logic                      new_bit;

   // Constant 4 is a single one in bit 2
   assign c4_in   = i_cnt0 ? 1'b0 : c4_q;
   assign pc4_bit = pc[0] ^ cnt2_q ^ c4_in;

   assign ci_in     = i_cnt0 ? 1'b0 : ci_q;
   assign pcimm_bit = pc[0] ^ i_imm ^ ci_in;

   assign new_bit = i_pc_jump ? pcimm_bit : pc4_bit;
   assign o_rd    = i_pc_rel ? pcimm_bit : pc4_bit;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc     <= RESET_PC;
         cnt1_q <= 1'b0;
         cnt2_q <= 1'b0;
         c4_q   <= 1'b0;
         ci_q   <= 1'b0;
      end else if (i_cnt_en) begin
         // Old PC shifts out the bottom while the new one fills from the top
         pc     <= {new_bit, pc[serv_pkg::XLEN-1:1]};
         cnt1_q <= i_cnt0;
         cnt2_q <= cnt1_q;
         c4_q   <= (pc[0] & cnt2_q) | (c4_in & (pc[0] ^ cnt2_q));
         ci_q   <= (pc[0] & i_imm) | (ci_in & (pc[0] ^ i_imm));
      end
   end

   assign o_ibus_adr = pc;

endmodule

`default_nettype wire

// ==== serv_rf_if.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_rf_if (
   input  logic                            i_cnt_en,
   input  serv_pkg::rd_src_t               i_rd_src,
   input  logic [serv_pkg::REG_ADDR_W-1:0] i_rd_addr,
   input  logic [serv_pkg::REG_ADDR_W-1:0] i_rs1_addr,
   input  logic [serv_pkg::REG_ADDR_W-1:0] i_rs2_addr,
   input  logic                            i_alu_rd,
   input  logic                            i_ctrl_rd,
   input  logic                            i_imm,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rreg0,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rreg1,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_wreg0,
   output logic                            o_wen0,
   output logic                            o_wdata0
);

   assign o_rreg0 = i_rs1_addr;
   assign o_rreg1 = i_rs2_addr;
   assign o_wreg0 = i_rd_addr;

   always_comb begin
      case (i_rd_src)
         serv_pkg::RD_ALU:  o_wdata0 = i_alu_rd;
         serv_pkg::RD_CTRL: o_wdata0 = i_ctrl_rd;
         // LUI writes the U-immediate as is
         serv_pkg::RD_IMM:  o_wdata0 = i_imm;
         default:           o_wdata0 = 1'b0;
      endcase
   end

   // x0 is never written
   assign o_wen0 = i_cnt_en & (i_rd_src != serv_pkg::RD_NONE) & (|i_rd_addr);

endmodule

`default_nettype wire

// ==== serv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module serv_core #(
   parameter logic [serv_pkg::XLEN-1:0] RESET_PC = serv_pkg::DEFAULT_RESET_PC
) (
   input  logic                                clk,
   input  logic                                i_rst_n,
   // Instruction bus
   output logic [serv_pkg::XLEN-1:0]           o_ibus_adr,
   output logic                                o_ibus_cyc,
   input  logic [serv_pkg::INSTR_W-1:0]        i_ibus_rdt,
   input  logic                                i_ibus_ack,
   // Register file
   output logic                                o_rf_rreq,
   output logic [serv_pkg::REG_ADDR_W-1:0]     o_rreg0,
   output logic [serv_pkg::REG_ADDR_W-1:0]     o_rreg1,
   output logic [serv_pkg::REG_ADDR_W-1:0]     o_wreg0,
   output logic                                o_wen0,
   output logic                                o_wdata0,
   input  logic                                i_rdata0,
   input  logic                                i_rdata1
);

   logic                            cnt_en;
   logic                            cnt0;

   serv_pkg::alu_op_t               alu_op;
   logic                            alu_sub;
   logic                            op_b_imm;
   serv_pkg::rd_src_t               rd_src;
   serv_pkg::imm_fmt_t              imm_fmt;
   logic                            pc_jump;
   logic                            pc_rel;

   logic                            imm;
   logic [serv_pkg::REG_ADDR_W-1:0] rd_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rs1_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rs2_addr;

   logic                            alu_rd;
   logic                            ctrl_rd;

   serv_state state (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq ),
      .o_cnt_en   (cnt_en    ),
      .o_cnt0     (cnt0      ),
      // Only the sequencer itself needs the last-cycle flag
      .o_cnt_done (          )
   );

   serv_decode decode (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_alu_op   (alu_op    ),
      .o_sub      (alu_sub   ),
      .o_op_b_imm (op_b_imm  ),
      .o_rd_src   (rd_src    ),
      .o_imm_fmt  (imm_fmt   ),
      .o_pc_jump  (pc_jump   ),
      .o_pc_rel   (pc_rel    )
   );

   serv_immdec immdec (
      .clk        (clk       ),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_imm_fmt  (imm_fmt   ),
      .i_cnt_en   (cnt_en    ),
      .o_imm      (imm       ),
      .o_rd_addr  (rd_addr   ),
      .o_rs1_addr (rs1_addr  ),
      .o_rs2_addr (rs2_addr  )
   );

   serv_alu alu (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_cnt_en   (cnt_en    ),
      .i_cnt0     (cnt0      ),
      .i_alu_op   (alu_op    ),
      .i_sub      (alu_sub   ),
      .i_op_b_imm (op_b_imm  ),
      .i_rs1      (i_rdata0  ),
      .i_rs2      (i_rdata1  ),
      .i_imm      (imm       ),
      .o_rd       (alu_rd    )
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) ctrl (
      .clk        (clk       ),
      .i_rst_n    (i_rst_n   ),
      .i_cnt_en   (cnt_en    ),
      .i_cnt0     (cnt0      ),
      .i_pc_jump  (pc_jump   ),
      .i_pc_rel   (pc_rel    ),
      .i_imm      (imm       ),
      .o_ibus_adr (o_ibus_adr),
      .o_rd       (ctrl_rd   )
   );

   serv_rf_if rf_if (
      .i_cnt_en   (cnt_en    ),
      .i_rd_src   (rd_src    ),
      .i_rd_addr  (rd_addr   ),
      .i_rs1_addr (rs1_addr  ),
      .i_rs2_addr (rs2_addr  ),
      .i_alu_rd   (alu_rd    ),
      .i_ctrl_rd  (ctrl_rd   ),
      .i_imm      (imm       ),
      .o_rreg0    (o_rreg0   ),
      .o_rreg1    (o_rreg1   ),
      .o_wreg0    (o_wreg0   ),
      .o_wen0     (o_wen0    ),
      .o_wdata0   (o_wdata0  )
   );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic o_clk
);

   initial begin
      o_clk = 1'b0;
      forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
   end

endmodule

`default_nettype wire

// ==== tb_serv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_serv_core;

   localparam logic [31:0] START_PC       = 32'h0000_0200;
   // 40 instructions of at most 40 cycles each
   localparam int          TIMEOUT_CYCLES = 40 * 40;

   // RV32I major opcodes
   localparam logic [6:0] OPC_R      = 7'b0110011;
   localparam logic [6:0] OPC_I      = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_CUSTOM = 7'b0001011;

   logic        clk;
   logic        rst_n;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] ibus_rdt;
   logic        ibus_ack;
   logic        rf_rreq;
   logic [4:0]  rreg0;
   logic [4:0]  rreg1;
   logic [4:0]  wreg0;
   logic        wen0;
   logic        wdata0;
   logic        rdata0;
   logic        rdata1;

   logic [31:0] regs [0:31];
   logic [31:0] imem [0:255];
   logic        imem_valid [0:255];
   integer      seed;

   // Bus and register file model
   logic        rst_seen;
   logic        in_fetch;
   int          wait_left;
   int          fetch_cnt;
   logic [31:0] fetch_adr;
   logic        rd_run;
   int          rd_bit;
   logic [31:0] rs1_word;
   logic [31:0] rs2_word;

   // Monitor
   int          cycle_cnt;
   logic        rst_low_prev;
   logic        prev_ack;
   logic        exec_on;
   int          exec_bit;
   int          wen_cycles;
   int          wen_total;
   logic        just_done;

   tb_clk_gen clk_gen (
      .o_clk (clk)
   );

   serv_core #(
      .RESET_PC (START_PC)
   ) dut (
      .clk        (clk     ),
      .i_rst_n    (rst_n   ),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_rf_rreq  (rf_rreq ),
      .o_rreg0    (rreg0   ),
      .o_rreg1    (rreg1   ),
      .o_wreg0    (wreg0   ),
      .o_wen0     (wen0    ),
      .o_wdata0   (wdata0  ),
      .i_rdata0   (rdata0  ),
      .i_rdata1   (rdata1  )
   );

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OPC_R};
   endfunction

   function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, OPC_I};
   endfunction

   function automatic logic [31:0] u_type_word(input logic [6:0] opc, input logic [19:0] imm,
                                               input logic [4:0] rd);
      return {imm, rd, opc};
   endfunction

   function automatic logic [31:0] jal_word(input logic [20:0] off, input logic [4:0] rd);
      return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
   endfunction

   function automatic logic [31:0] sext12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   // Unloaded words decode as a custom opcode, which the core skips
   function automatic logic [31:0] instr_at(input logic [31:0] adr);
      if (imem_valid[adr[9:2]]) begin
         return imem[adr[9:2]];
      end else begin
         return {adr[24:0] ^ adr[31:7], OPC_CUSTOM};
      end
   endfunction

   // Instruction bus and serial register file read side
   always @(negedge clk) begin
      if (rst_seen !== 1'b1) begin
         ibus_ack  = 1'b0;
         ibus_rdt  = '0;
         in_fetch  = 1'b0;
         fetch_cnt = 0;
         rd_run    = 1'b0;
         rdata0    = 1'b0;
         rdata1    = 1'b0;
      end else begin
         if (ibus_ack) begin
            ibus_ack = 1'b0;
            ibus_rdt = '0;
         end else if (ibus_cyc) begin
            if (!in_fetch) begin
               in_fetch  = 1'b1;
               fetch_adr = ibus_adr;
               fetch_cnt = fetch_cnt + 1;
               wait_left = $unsigned($random(seed)) % 4;
            end
            assert (ibus_adr === fetch_adr) else
               stop_with_error($sformatf("FAIL o_ibus_adr: got 0x%08h, expected 0x%08h",
                                         ibus_adr, fetch_adr));
            if (wait_left == 0) begin
               ibus_ack = 1'b1;
               ibus_rdt = instr_at(ibus_adr);
               in_fetch = 1'b0;
            end else begin
               wait_left = wait_left - 1;
            end
         end else begin
            assert (!in_fetch) else stop_with_error("bus cycle dropped before the acknowledge");
         end
         if (rf_rreq) begin
            rs1_word = regs[rreg0];
            rs2_word = regs[rreg1];
            rd_bit   = 0;
            rd_run   = 1'b1;
         end else if (rd_run) begin
            rdata0 = rs1_word[rd_bit];
            rdata1 = rs2_word[rd_bit];
            rd_bit = rd_bit + 1;
            rd_run = (rd_bit < 32);
         end else begin
            rdata0 = 1'b0;
            rdata1 = 1'b0;
         end
      end
   end

   // Timing checks and serial write-back, sampled before the edge updates
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         stop_with_error($sformatf("timeout, tests still running after %0d cycles", cycle_cnt));
      end
      if (!rst_n) begin
         if (rst_low_prev) begin
            assert (ibus_cyc === 1'b0 && rf_rreq === 1'b0 && wen0 === 1'b0) else
               stop_with_error("bus cycle, read request or write enable active in reset");
         end
         rst_low_prev = 1'b1;
         prev_ack     = 1'b0;
         exec_on      = 1'b0;
         just_done    = 1'b0;
         wen_total    = 0;
      end else begin
         rst_low_prev = 1'b0;
         if (exec_on) begin
            assert (ibus_cyc === 1'b0) else stop_with_error("bus cycle during execute");
            if (wen0) begin
               assert (wen_cycles == exec_bit) else
                  stop_with_error("write enable not contiguous from the first execute cycle");
               regs[wreg0][exec_bit] = wdata0;
               wen_cycles = wen_cycles + 1;
               wen_total  = wen_total + 1;
            end
            if (exec_bit == 31) begin
               exec_on   = 1'b0;
               just_done = 1'b1;
               assert (wen_cycles == 0 || wen_cycles == 32) else
                  stop_with_error($sformatf("write enable high for %0d cycles", wen_cycles));
            end else begin
               exec_bit = exec_bit + 1;
            end
         end else begin
            assert (wen0 === 1'b0) else stop_with_error("write enable outside execute");
            if (just_done) begin
               assert (ibus_cyc === 1'b1) else
                  stop_with_error("next fetch did not start right after execute");
               just_done = 1'b0;
            end
         end
         assert (rf_rreq === prev_ack) else
            stop_with_error("read request not exactly one cycle after the acknowledge");
         if (rf_rreq) begin
            exec_on    = 1'b1;
            exec_bit   = 0;
            wen_cycles = 0;
         end
         prev_ack = ibus_ack;
      end
      rst_seen = rst_n;
   end

   // Leaves reset low so the test can load memory and registers
   task automatic hold_reset();
      @(negedge clk);
      rst_n = 1'b0;
      repeat (3) @(negedge clk);
      for (int i = 0; i < 256; i++) begin
         imem_valid[i] = 1'b0;
      end
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
   endtask

   task automatic release_reset();
      @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic load_instr(input int n, input logic [31:0] word);
      logic [31:0] adr;
      adr = START_PC + 4 * n;
      imem[adr[9:2]]       = word;
      imem_valid[adr[9:2]] = 1'b1;
   endtask

   task automatic check_reg(input int idx, input logic [31:0] exp);
      assert (regs[idx] === exp) else
         stop_with_error($sformatf("FAIL x%0d: got 0x%08h, expected 0x%08h",
                                   idx, regs[idx], exp));
   endtask

   task automatic check_fetch(input logic [31:0] exp);
      assert (fetch_adr === exp) else
         stop_with_error($sformatf("FAIL o_ibus_adr: got 0x%08h, expected 0x%08h",
                                   fetch_adr, exp));
   endtask

   task automatic reset_behavior();
      hold_reset();
      release_reset();
      wait (fetch_cnt == 1);
      check_fetch(START_PC);
      wait (fetch_cnt == 2);
      check_fetch(START_PC + 4);
      assert (wen_total == 0) else stop_with_error("unsupported opcode wrote the register file");
   endtask

   task automatic reg_reg_ops();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      a = $random(seed);
      b = $random(seed);
      c = 32'h8000_0001;
      hold_reset();
      regs[1] = a;
      regs[2] = b;
      regs[3] = c;
      load_instr(0, r_type_word(7'h00, 2, 1, 3'b000, 5));
      load_instr(1, r_type_word(7'h20, 2, 1, 3'b000, 6));
      load_instr(2, r_type_word(7'h00, 2, 1, 3'b100, 7));
      load_instr(3, r_type_word(7'h00, 2, 1, 3'b110, 8));
      load_instr(4, r_type_word(7'h00, 2, 1, 3'b111, 9));
      load_instr(5, r_type_word(7'h00, 2, 1, 3'b000, 0));
      load_instr(6, r_type_word(7'h20, 1, 3, 3'b000, 10));
      release_reset();
      wait (fetch_cnt == 8);
      check_reg(5, a + b);
      check_reg(6, a - b);
      check_reg(7, a ^ b);
      check_reg(8, a | b);
      check_reg(9, a & b);
      check_reg(0, 32'h0);
      check_reg(10, c - a);
      check_fetch(START_PC + 28);
   endtask

   task automatic imm_ops();
      logic [31:0] a;
      a = 32'h0000_f00f;
      hold_reset();
      regs[1] = a;
      load_instr(0, i_type_word(12'h7ff, 1, 3'b000, 11));
      load_instr(1, i_type_word(12'hffb, 1, 3'b000, 12));
      load_instr(2, i_type_word(12'hfff, 1, 3'b100, 13));
      load_instr(3, i_type_word(12'h800, 1, 3'b110, 14));
      load_instr(4, i_type_word(12'hff0, 1, 3'b111, 15));
      load_instr(5, i_type_word(12'h0f0, 1, 3'b111, 16));
      release_reset();
      wait (fetch_cnt == 7);
      check_reg(11, a + sext12(12'h7ff));
      check_reg(12, a + sext12(12'hffb));
      check_reg(13, a ^ sext12(12'hfff));
      check_reg(14, a | sext12(12'h800));
      check_reg(15, a & sext12(12'hff0));
      check_reg(16, a & sext12(12'h0f0));
      check_fetch(START_PC + 24);
   endtask

   task automatic upper_imm_ops();
      hold_reset();
      regs[19] = 32'h5555_aaaa;
      load_instr(0, u_type_word(OPC_LUI, 20'habcde, 17));
      load_instr(1, u_type_word(OPC_AUIPC, 20'h80012, 18));
      load_instr(2, u_type_word(OPC_CUSTOM, 20'h12345, 19));
      release_reset();
      wait (fetch_cnt == 4);
      check_reg(17, 32'habcde_000);
      check_reg(18, START_PC + 4 + 32'h80012_000);
      check_reg(19, 32'h5555_aaaa);
      check_fetch(START_PC + 12);
   endtask

   task automatic jal_jump();
      hold_reset();
      load_instr(0, jal_word(21'd12, 20));
      // Backwards by 8 from the jump target
      load_instr(3, jal_word(21'h1f_fff8, 21));
      release_reset();
      wait (fetch_cnt == 2);
      check_fetch(START_PC + 12);
      wait (fetch_cnt == 3);
      check_fetch(START_PC + 4);
      check_reg(20, START_PC + 4);
      check_reg(21, START_PC + 16);
   endtask

   task automatic random_ack_timing();
      logic [11:0] step;
      hold_reset();
      regs[1] = 32'h0000_0001;
      for (int n = 0; n < 4; n++) begin
         step = n + 1;
         load_instr(n, i_type_word(step, 1, 3'b000, 1));
      end
      release_reset();
      wait (fetch_cnt == 5);
      // Every instruction writes x1 for a full pass
      assert (wen_total == 4 * 32) else
         stop_with_error($sformatf("FAIL o_wen0: high for 0x%0h cycles, expected 0x%0h",
                                   wen_total, 4 * 32));
      check_reg(1, 32'd11);
   endtask

   initial begin
      seed          = 32'h328f344b;
      rst_n         = 1'b0;
      ibus_ack      = 1'b0;
      ibus_rdt      = '0;
      rdata0        = 1'b0;
      rdata1        = 1'b0;
      rst_seen      = 1'b0;
      cycle_cnt     = 0;
      rst_low_prev  = 1'b0;
      prev_ack      = 1'b0;
      exec_on       = 1'b0;
      just_done     = 1'b0;
      wen_total     = 0;
      fetch_cnt     = 0;
      reset_behavior();
      reg_reg_ops();
      imm_ops();
      upper_imm_ops();
      jal_jump();
      random_ack_timing();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
serv_pkg.sv
serv_state.sv
serv_decode.sv
serv_immdec.sv
serv_alu.sv
serv_ctrl.sv
serv_rf_if.sv
serv_core.sv
tb_clk_gen.sv
tb_serv_core.sv

// ==== Bender.yml ====
package:
  name: serv_core

sources:
  - serv_pkg.sv
  - serv_state.sv
  - serv_decode.sv
  - serv_immdec.sv
  - serv_alu.sv
  - serv_ctrl.sv
  - serv_rf_if.sv
  - serv_core.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_serv_core.sv
